/* common/ps2_pkg.sv */
package ps2_pkg;

	////////////////////////////////////////
	// Frame content
	////////////////////////////////////////

	// One data byte as it comes off the wire
	typedef logic [7:0] ps2_byte_t;

	// Received frame with its check results
	typedef struct packed {
		ps2_byte_t data;
		logic      parity_err;
		logic      stop_err;
	} frame_t;

	// Receiver FSM
	typedef enum logic [2:0] {
		RX_IDLE,
		RX_DATA,
		RX_PARITY,
		RX_STOP,
		RX_DONE
	} rx_state_t;

	////////////////////////////////////////
	// Line timing
	////////////////////////////////////////

	// Equal samples needed before the filtered clock follows the line
	localparam int FILTER_LEN = 8;

	// System clocks without a falling edge before a partial frame is dropped
	localparam int TIMEOUT_CYCLES = 50000;

	typedef logic [15:0] timeout_cnt_t;

endpackage

/* common/kbd_pkg.sv */
package kbd_pkg;

	////////////////////////////////////////
	// Key events
	////////////////////////////////////////

	typedef logic [7:0] scancode_t;

	// Set-2 code plus the prefix flags seen before it
	typedef struct packed {
		scancode_t code;
		logic      extended;
		logic      released;
	} key_event_t;

	localparam scancode_t PREFIX_EXT   = 8'he0;
	localparam scancode_t PREFIX_BREAK = 8'hf0;

	////////////////////////////////////////
	// Register map
	////////////////////////////////////////

	typedef logic [2:0]  reg_addr_t;
	typedef logic [15:0] reg_data_t;
	typedef logic [7:0]  err_cnt_t;

	localparam reg_addr_t ADDR_CTRL     = 3'd0;
	localparam reg_addr_t ADDR_EVENT    = 3'd1;
	localparam reg_addr_t ADDR_STATUS   = 3'd2;
	localparam reg_addr_t ADDR_ERR_PAR  = 3'd3;
	localparam reg_addr_t ADDR_ERR_STOP = 3'd4;
	localparam reg_addr_t ADDR_ERR_TMO  = 3'd5;

endpackage

/* ps2_rx/ps2_line_filter.sv */
`timescale 1ns/1ns

module ps2_line_filter (
	input  logic clk,
	input  logic rst_n,
	input  logic ps2clk,
	input  logic ps2data,
	output logic clk_fall,
	output logic data_sync,
	output logic line_idle
);
	import ps2_pkg::*;

	localparam int CNT_W = $clog2(FILTER_LEN);

	logic [1:0]       clk_meta;
	logic [1:0]       data_meta;
	logic [CNT_W-1:0] agree_cnt;
	logic             clk_filt;
	logic             clk_filt_q;

	// Both lines idle high, so the flops come out of reset high
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			clk_meta   <= 2'b11;
			data_meta  <= 2'b11;
			agree_cnt  <= '0;
			clk_filt   <= 1'b1;
			clk_filt_q <= 1'b1;
		end
		else
		begin
			clk_meta   <= {clk_meta[0], ps2clk};
			data_meta  <= {data_meta[0], ps2data};
			clk_filt_q <= clk_filt;
			// Count samples that disagree with the filtered level
			if (clk_meta[1] == clk_filt)
				agree_cnt <= '0;
			else if (agree_cnt == CNT_W'(FILTER_LEN - 1))
			begin
				clk_filt  <= clk_meta[1];
				agree_cnt <= '0;
			end
			else
				agree_cnt <= agree_cnt + 1'b1;
		end
	end

	assign clk_fall  = clk_filt_q & ~clk_filt;
	assign data_sync = data_meta[1];
	assign line_idle = clk_filt;

endmodule

/* ps2_rx/ps2_frame_rx.sv */
`timescale 1ns/1ns

module ps2_frame_rx (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            rx_enable,
	input  logic            clk_fall,
	input  logic            data_sync,
	input  logic            line_idle,
	output ps2_pkg::frame_t frame,
	output logic            frame_valid,
	output logic            timeout
);
	import ps2_pkg::*;

	rx_state_t    state;
	ps2_byte_t    shreg;
	logic [2:0]   bit_cnt;
	timeout_cnt_t tmo_cnt;
	logic         par_err;
	logic         stop_err;
	logic         tmo_hit;

	assign tmo_hit = (tmo_cnt == timeout_cnt_t'(TIMEOUT_CYCLES - 1));

	////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state       <= RX_IDLE;
			bit_cnt     <= '0;
			tmo_cnt     <= '0;
			frame_valid <= 1'b0;
			timeout     <= 1'b0;
		end
		else
		begin
			frame_valid <= 1'b0;
			timeout     <= 1'b0;

			case (state)
				RX_IDLE:
				begin
					bit_cnt <= '0;
					tmo_cnt <= '0;
					// Start bit is a low data line at the first edge
					if (rx_enable && clk_fall && !data_sync)
						state <= RX_DATA;
				end

				RX_DATA, RX_PARITY, RX_STOP:
				begin
					if (clk_fall)
					begin
						tmo_cnt <= '0;
						case (state)
							RX_DATA:
							begin
								bit_cnt <= bit_cnt + 1'b1;
								if (bit_cnt == 3'd7)
									state <= RX_PARITY;
							end
							RX_PARITY:
								state <= RX_STOP;
							default:
							begin
								state       <= RX_DONE;
								frame_valid <= 1'b1;
							end
						endcase
					end
					else if (tmo_hit)
					begin
						// Partial frame is dropped
						state   <= RX_IDLE;
						timeout <= 1'b1;
					end
					// Device releases the clock high while it stalls
					else if (line_idle)
						tmo_cnt <= tmo_cnt + 1'b1;
				end

				RX_DONE:
					state <= RX_IDLE;

				default:
					state <= RX_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// Data path
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (clk_fall)
		begin
			case (state)
				RX_IDLE:
				begin
					par_err  <= 1'b0;
					stop_err <= 1'b0;
				end
				// LSB arrives first
				RX_DATA:
					shreg <= {data_sync, shreg[7:1]};
				// Data plus parity must hold an odd number of ones
				RX_PARITY:
					par_err <= ~^{shreg, data_sync};
				RX_STOP:
					stop_err <= ~data_sync;
			endcase
		end
	end

	assign frame = '{data: shreg, parity_err: par_err, stop_err: stop_err};

endmodule

/* design/scan_decoder.sv */
`timescale 1ns/1ns

module scan_decoder (
	input  logic                clk,
	input  logic                rst_n,
	input  ps2_pkg::frame_t     frame,
	input  logic                frame_valid,
	output kbd_pkg::key_event_t key_event,
	output logic                event_valid
);
	import kbd_pkg::*;

	logic ext_flag;
	logic brk_flag;
	logic frame_ok;

	assign frame_ok = frame_valid && !frame.parity_err && !frame.stop_err;

	////////////////////////////////////////
	// Prefix flags and event strobe
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ext_flag    <= 1'b0;
			brk_flag    <= 1'b0;
			event_valid <= 1'b0;
		end
		else
		begin
			event_valid <= 1'b0;
			if (frame_valid && !frame_ok)
			begin
				// A bad byte breaks any sequence in progress
				ext_flag <= 1'b0;
				brk_flag <= 1'b0;
			end
			else if (frame_ok)
			begin
				if (frame.data == PREFIX_EXT)
					ext_flag <= 1'b1;
				else if (frame.data == PREFIX_BREAK)
					brk_flag <= 1'b1;
				else
				begin
					event_valid <= 1'b1;
					ext_flag    <= 1'b0;
					brk_flag    <= 1'b0;
				end
			end
		end
	end

	// Final byte of a sequence, with the flags gathered so far
	always_ff @(posedge clk)
	begin
		if (frame_ok && frame.data != PREFIX_EXT && frame.data != PREFIX_BREAK)
		begin
			key_event.code     <= frame.data;
			key_event.extended <= ext_flag;
			key_event.released <= brk_flag;
		end
	end

endmodule

/* design/kbd_regs.sv */
`timescale 1ns/1ns

module kbd_regs (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                reg_wr,
	input  logic                reg_rd,
	input  kbd_pkg::reg_addr_t  reg_addr,
	input  kbd_pkg::reg_data_t  reg_wdata,
	input  kbd_pkg::key_event_t key_event,
	input  logic                event_valid,
	input  ps2_pkg::frame_t     frame,
	input  logic                frame_valid,
	input  logic                timeout,
	output kbd_pkg::reg_data_t  reg_rdata,
	output logic                rx_enable,
	output logic                irq
);
	import kbd_pkg::*;

	key_event_t ev_hold;
	logic       irq_enable;
	logic       pending;
	logic       overrun;
	logic       pending_d;
	logic       overrun_d;
	logic       ev_read;
	logic [2:0] err_inc;
	err_cnt_t   err_cnt [3];

	assign ev_read = reg_rd && (reg_addr == ADDR_EVENT);

	// Order follows the register map: parity, stop, timeout
	assign err_inc = {timeout, frame_valid & frame.stop_err, frame_valid & frame.parity_err};

	////////////////////////////////////////
	// Control and event holding
	////////////////////////////////////////

	// New event wins over a read in the same cycle
	always_comb
	begin
		pending_d = ev_read ? 1'b0 : pending;
		overrun_d = ev_read ? 1'b0 : overrun;
		if (event_valid)
		begin
			pending_d = 1'b1;
			overrun_d = overrun_d | (pending & ~ev_read);
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rx_enable  <= 1'b0;
			irq_enable <= 1'b0;
			pending    <= 1'b0;
			overrun    <= 1'b0;
			irq        <= 1'b0;
		end
		else
		begin
			if (reg_wr && reg_addr == ADDR_CTRL)
			begin
				rx_enable  <= reg_wdata[0];
				irq_enable <= reg_wdata[1];
			end
			pending <= pending_d;
			overrun <= overrun_d;
			irq     <= pending_d & irq_enable;
		end
	end

	always_ff @(posedge clk)
	begin
		if (event_valid)
			ev_hold <= key_event;
	end

	////////////////////////////////////////
	// Error counters
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 3; i++)
				err_cnt[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < 3; i++)
			begin
				// Clear on any write, otherwise count up and stick at max
				if (reg_wr && reg_addr == ADDR_ERR_PAR + reg_addr_t'(i))
					err_cnt[i] <= '0;
				else if (err_inc[i] && err_cnt[i] != '1)
					err_cnt[i] <= err_cnt[i] + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Read mux
	////////////////////////////////////////

	always_comb
	begin
		reg_rdata = '0;
		case (reg_addr)
			ADDR_CTRL:     reg_rdata = {14'd0, irq_enable, rx_enable};
			ADDR_EVENT:    reg_rdata = {pending, 5'd0, ev_hold};
			ADDR_STATUS:   reg_rdata = {14'd0, overrun, pending};
			ADDR_ERR_PAR:  reg_rdata = {8'd0, err_cnt[0]};
			ADDR_ERR_STOP: reg_rdata = {8'd0, err_cnt[1]};
			ADDR_ERR_TMO:  reg_rdata = {8'd0, err_cnt[2]};
			default:       reg_rdata = '0;
		endcase
	end

endmodule

/* design/kbd_top.sv */
`timescale 1ns/1ns

module kbd_top (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               ps2clk,
	input  logic               ps2data,
	input  logic               reg_wr,
	input  logic               reg_rd,
	input  kbd_pkg::reg_addr_t reg_addr,
	input  kbd_pkg::reg_data_t reg_wdata,
	output kbd_pkg::reg_data_t reg_rdata,
	output logic               irq
);
	import ps2_pkg::*;
	import kbd_pkg::*;

	logic       clk_fall;
	logic       data_sync;
	logic       line_idle;
	logic       rx_enable;
	frame_t     frame;
	logic       frame_valid;
	logic       timeout;
	key_event_t key_event;
	logic       event_valid;

	////////////////////////////////////////
	// PS/2 receive path
	////////////////////////////////////////

	ps2_line_filter i_ps2_line_filter (
		.clk       (clk),
		.rst_n     (rst_n),
		.ps2clk    (ps2clk),
		.ps2data   (ps2data),
		.clk_fall  (clk_fall),
		.data_sync (data_sync),
		.line_idle (line_idle)
	);

	ps2_frame_rx i_ps2_frame_rx (
		.clk         (clk),
		.rst_n       (rst_n),
		.rx_enable   (rx_enable),
		.clk_fall    (clk_fall),
		.data_sync   (data_sync),
		.line_idle   (line_idle),
		.frame       (frame),
		.frame_valid (frame_valid),
		.timeout     (timeout)
	);

	scan_decoder i_scan_decoder (
		.clk         (clk),
		.rst_n       (rst_n),
		.frame       (frame),
		.frame_valid (frame_valid),
		.key_event   (key_event),
		.event_valid (event_valid)
	);

	// Register block also watches the raw frame stream for error counts
	kbd_regs i_kbd_regs (
		.clk         (clk),
		.rst_n       (rst_n),
		.reg_wr      (reg_wr),
		.reg_rd      (reg_rd),
		.reg_addr    (reg_addr),
		.reg_wdata   (reg_wdata),
		.key_event   (key_event),
		.event_valid (event_valid),
		.frame       (frame),
		.frame_valid (frame_valid),
		.timeout     (timeout),
		.reg_rdata   (reg_rdata),
		.rx_enable   (rx_enable),
		.irq         (irq)
	);

endmodule

/* verif/kbd_tb.sv */
`timescale 1ns/1ns

module kbd_tb;
	import ps2_pkg::*;
	import kbd_pkg::*;

	localparam int CLK_PERIOD   = 20;
	localparam int HALF_BIT     = 40;
	localparam int FRAME_CYCLES = 11 * 2 * HALF_BIT + HALF_BIT;
	localparam int IRQ_WAIT     = 200;
	localparam int NUM_CASES    = 10;
	localparam int NUM_RANDOM   = 8;
	localparam int WATCHDOG_CYCLES =
		(NUM_CASES * 3 + NUM_RANDOM + 6) * (FRAME_CYCLES + IRQ_WAIT) * 2 + 2 * TIMEOUT_CYCLES;

	// Error injection on the last byte of a sequence
	localparam logic [1:0] INJ_NONE    = 2'd0;
	localparam logic [1:0] INJ_PAR     = 2'd1;
	localparam logic [1:0] INJ_STOP    = 2'd2;
	localparam logic [1:0] INJ_ABANDON = 2'd3;

	typedef struct packed {
		logic [1:0]  nbytes;
		logic [23:0] seq;
		logic [1:0]  inject;
		logic        has_event;
		scancode_t   exp_code;
		logic        exp_ext;
		logic        exp_rel;
		logic [1:0]  d_par;
		logic [1:0]  d_stop;
		logic [1:0]  d_tmo;
	} frame_case_t;

	logic        clk;
	logic        rst_n;
	logic        ps2clk;
	logic        ps2data;
	logic        reg_wr;
	logic        reg_rd;
	reg_addr_t   reg_addr;
	reg_data_t   reg_wdata;
	reg_data_t   reg_rdata;
	logic        irq;
	frame_case_t cases [NUM_CASES];
	err_cnt_t    exp_par;
	err_cnt_t    exp_stop;
	err_cnt_t    exp_tmo;
	integer      seed;

	kbd_top i_kbd_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.ps2clk    (ps2clk),
		.ps2data   (ps2data),
		.reg_wr    (reg_wr),
		.reg_rd    (reg_rd),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.reg_rdata (reg_rdata),
		.irq       (irq)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run("Watchdog expired before the test sequence finished");
	end

	////////////////////////////////////////
	// Failure and checks
	////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check(input logic [15:0] actual, input logic [15:0] expected,
		input string what);
		if (actual !== expected)
			abort_run($sformatf("ERROR at %0t ns: %s got %h expected %h",
				$time, what, actual, expected));
	endtask

	task automatic gap(input int cycles);
		repeat (cycles) @(posedge clk);
	endtask

	////////////////////////////////////////
	// Register bus
	////////////////////////////////////////

	task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
		@(posedge clk);
		reg_addr  <= addr;
		reg_wdata <= data;
		reg_wr    <= 1'b1;
		@(posedge clk);
		reg_wr <= 1'b0;
	endtask

	// Read data is sampled mid-cycle, before the edge that sees reg_rd
	task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
		@(posedge clk);
		reg_addr <= addr;
		reg_rd   <= 1'b1;
		@(negedge clk);
		data = reg_rdata;
		@(posedge clk);
		reg_rd <= 1'b0;
	endtask

	////////////////////////////////////////
	// PS/2 device model
	////////////////////////////////////////

	// Start, data LSB first, odd parity, stop
	task automatic send_byte(input logic [7:0] data, input logic [1:0] inject, input int nbits);
		logic [10:0] bits;
		bits = {inject != INJ_STOP, (~^data) ^ (inject == INJ_PAR), data, 1'b0};
		for (int i = 0; i < nbits; i++)
		begin
			@(posedge clk);
			ps2data <= bits[i];
			gap(HALF_BIT / 2);
			ps2clk <= 1'b0;
			gap(HALF_BIT);
			ps2clk <= 1'b1;
			gap(HALF_BIT / 2 - 1);
		end
		ps2data <= 1'b1;
		gap(HALF_BIT);
	endtask

	task automatic wait_irq();
		int waited;
		waited = 0;
		@(negedge clk);
		while (!irq && waited < IRQ_WAIT)
		begin
			@(negedge clk);
			waited++;
		end
		if (!irq)
			abort_run("irq did not rise after a complete key sequence");
	endtask

	task automatic check_counters(input string tag);
		reg_data_t rd;
		reg_read(ADDR_ERR_PAR, rd);
		check(rd, {8'd0, exp_par}, {tag, " parity count"});
		reg_read(ADDR_ERR_STOP, rd);
		check(rd, {8'd0, exp_stop}, {tag, " stop count"});
		reg_read(ADDR_ERR_TMO, rd);
		check(rd, {8'd0, exp_tmo}, {tag, " timeout count"});
	endtask

	// Read the event, then confirm pending and irq have dropped
	task automatic take_event(input scancode_t code, input logic ext, input logic rel,
		input string tag);
		reg_data_t rd;
		reg_read(ADDR_EVENT, rd);
		check(rd, {1'b1, 5'd0, code, ext, rel}, {tag, " event"});
		reg_read(ADDR_STATUS, rd);
		check(rd, 16'd0, {tag, " status after read"});
		@(negedge clk);
		check({15'd0, irq}, 16'd0, {tag, " irq after read"});
	endtask

	////////////////////////////////////////
	// Frame table
	////////////////////////////////////////

	function automatic frame_case_t make_case(input logic [1:0] n, input logic [23:0] seq,
		input logic [1:0] inject, input logic ev, input scancode_t code, input logic ext,
		input logic rel, input logic [1:0] dp, input logic [1:0] ds, input logic [1:0] dt);
		return '{nbytes: n, seq: seq, inject: inject, has_event: ev, exp_code: code,
			exp_ext: ext, exp_rel: rel, d_par: dp, d_stop: ds, d_tmo: dt};
	endfunction

	task automatic apply_case(input frame_case_t fc, input int idx);
		reg_data_t rd;
		logic [7:0] cur;
		string tag;
		tag = $sformatf("case %0d", idx);
		for (int b = 0; b < fc.nbytes; b++)
		begin
			cur = fc.seq[8 * (fc.nbytes - 1 - b) +: 8];
			if (b == fc.nbytes - 1)
				send_byte(cur, fc.inject, (fc.inject == INJ_ABANDON) ? 4 : 11);
			else
				send_byte(cur, INJ_NONE, 11);
		end
		if (fc.inject == INJ_ABANDON)
			gap(TIMEOUT_CYCLES + 1000);
		if (fc.has_event)
		begin
			wait_irq();
			take_event(fc.exp_code, fc.exp_ext, fc.exp_rel, tag);
		end
		else
		begin
			gap(IRQ_WAIT);
			reg_read(ADDR_STATUS, rd);
			check(rd, 16'd0, {tag, " no event expected"});
		end
		exp_par  = exp_par + fc.d_par;
		exp_stop = exp_stop + fc.d_stop;
		exp_tmo  = exp_tmo + fc.d_tmo;
		check_counters(tag);
	endtask

	initial
	begin
		reg_data_t rd;
		integer rnd;
		ps2clk    = 1'b1;
		ps2data   = 1'b1;
		reg_wr    = 1'b0;
		reg_rd    = 1'b0;
		reg_addr  = '0;
		reg_wdata = '0;
		rst_n     = 1'b0;
		exp_par   = '0;
		exp_stop  = '0;
		exp_tmo   = '0;
		seed      = 32'hb824c3c5;

		cases[0] = make_case(1, 24'h00001c, INJ_NONE, 1, 8'h1c, 0, 0, 0, 0, 0);
		cases[1] = make_case(2, 24'h00e075, INJ_NONE, 1, 8'h75, 1, 0, 0, 0, 0);
		cases[2] = make_case(2, 24'h00f01c, INJ_NONE, 1, 8'h1c, 0, 1, 0, 0, 0);
		cases[3] = make_case(3, 24'he0f075, INJ_NONE, 1, 8'h75, 1, 1, 0, 0, 0);
		// Errored byte throws away the prefix before it
		cases[4] = make_case(2, 24'h00e01c, INJ_PAR, 0, 8'h00, 0, 0, 1, 0, 0);
		cases[5] = make_case(1, 24'h00001c, INJ_NONE, 1, 8'h1c, 0, 0, 0, 0, 0);
		cases[6] = make_case(2, 24'h00f01c, INJ_STOP, 0, 8'h00, 0, 0, 0, 1, 0);
		cases[7] = make_case(1, 24'h00001c, INJ_NONE, 1, 8'h1c, 0, 0, 0, 0, 0);
		cases[8] = make_case(1, 24'h000029, INJ_ABANDON, 0, 8'h00, 0, 0, 0, 0, 1);
		cases[9] = make_case(1, 24'h00005a, INJ_NONE, 1, 8'h5a, 0, 0, 0, 0, 0);

		gap(16);
		rst_n <= 1'b1;
		gap(4);

		reg_write(ADDR_CTRL, 16'h0003);
		reg_read(ADDR_CTRL, rd);
		check(rd, 16'h0003, "control readback");

		for (int i = 0; i < NUM_CASES; i++)
			apply_case(cases[i], i);

		// Second event lands on top of an unread one
		send_byte(8'h1c, INJ_NONE, 11);
		wait_irq();
		send_byte(8'h32, INJ_NONE, 11);
		gap(20);
		reg_read(ADDR_STATUS, rd);
		check(rd, 16'h0003, "overrun status");
		take_event(8'h32, 1'b0, 1'b0, "overrun");

		// Receiver off, so nothing starts
		reg_write(ADDR_CTRL, 16'h0002);
		send_byte(8'h1c, INJ_NONE, 11);
		send_byte(8'h1c, INJ_PAR, 11);
		gap(IRQ_WAIT);
		reg_read(ADDR_STATUS, rd);
		check(rd, 16'd0, "disabled receiver status");
		check_counters("disabled receiver");
		reg_write(ADDR_CTRL, 16'h0003);

		reg_write(ADDR_ERR_PAR, 16'hffff);
		reg_write(ADDR_ERR_STOP, 16'h0000);
		reg_write(ADDR_ERR_TMO, 16'h1234);
		exp_par  = '0;
		exp_stop = '0;
		exp_tmo  = '0;
		check_counters("cleared");

		for (int n = 0; n < NUM_RANDOM; n++)
		begin
			do
				rnd = $random(seed);
			while (rnd[7:0] == PREFIX_EXT || rnd[7:0] == PREFIX_BREAK);
			send_byte(rnd[7:0], INJ_NONE, 11);
			wait_irq();
			take_event(rnd[7:0], 1'b0, 1'b0, $sformatf("random %0d", n));
		end
		check_counters("after random bytes");

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* project.f */
common/ps2_pkg.sv
common/kbd_pkg.sv
ps2_rx/ps2_line_filter.sv
ps2_rx/ps2_frame_rx.sv
design/scan_decoder.sv
design/kbd_regs.sv
design/kbd_top.sv
verif/kbd_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the keyboard receiver testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module kbd_tb -f project.f -o kbd_sim

# The run counts as passed only if the pass line shows up
./obj_dir/kbd_sim | tee /dev/stderr | grep "ALL TESTS PASSED" > /dev/null

echo "Simulation finished successfully"
